//--- project.f
pmu_event_pkg.sv
pmu_count_pkg.sv
pmu_event_router.sv
pmu_counter_bank.sv
pmu_intr_monitor.sv
pmu_top.sv
pmu_tb_props.sv
pmu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the PMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module pmu_tb -o pmu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/pmu_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1

//--- pmu_tb.sv
// PMU testbench
// Reference model of routing, counting and interrupts checked every clock edge

`timescale 1ns/10ps
`default_nettype none

module pmu_tb;

    import pmu_event_pkg::*;
    import pmu_count_pkg::*;

    // Longest wait for a flag in cycles
    localparam int WAIT_MAX = 20;

    logic                    clk_i;
    logic                    rstn_i;
    soc_events_t             events_i;
    ev_sel_t [N_COUNTERS-1:0] route_sel_i;
    selftest_t               selftest_i;
    logic                    cnt_en_i;
    logic                    cnt_softrst_i;
    logic                    cnt_we_i;
    cnt_idx_t                cnt_idx_i;
    count_t                  cnt_wdata_i;
    logic                    ovf_en_i;
    logic                    ovf_softrst_i;
    cnt_mask_t               ovf_mask_i;
    cnt_mask_t               quota_mask_i;
    quota_t                  quota_limit_i;
    count_t [N_COUNTERS-1:0] counts_o;
    cnt_mask_t               ovf_vect_o;
    logic                    intr_overflow_o;
    logic                    intr_quota_o;

    // Model state lags the sampled inputs by one edge
    cnt_mask_t   m_hits;
    count_t      m_cnt [N_COUNTERS];
    cnt_mask_t   m_wrap;
    cnt_mask_t   m_ovf;
    logic        m_quota;
    int          check_errs;
    int          timeout_errs;
    quota_t      q_sum;

    pmu_top dut_i (.*);

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic model_hit(input int i);
        case (selftest_i)
            ST_ALL_ON:  return 1'b1;
            ST_ALL_OFF: return 1'b0;
            ST_ONE_ON:  return (i == 0);
            default:    return events_i[route_sel_i[i]];
        endcase
    endfunction

    function automatic quota_t masked_sum(input cnt_mask_t mask);
        quota_t sum;
        sum = '0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            if (mask[i]) begin
                sum = sum + quota_t'(m_cnt[i]);
            end
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        assert (exp == got) else begin
            check_errs++;
            $display("ERR %0t %s exp=%0h got=%0h", $time, name, exp, got);
        end
    endtask

    // Checks read pre-edge values and updates land after the edge
    always @(posedge clk_i) begin
        if (!rstn_i) begin
            m_hits  <= '0;
            m_wrap  <= '0;
            m_ovf   <= '0;
            m_quota <= 1'b0;
            for (int i = 0; i < N_COUNTERS; i++) begin
                m_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N_COUNTERS; i++) begin
                check_value($sformatf("counts_o[%0d]", i), m_cnt[i], counts_o[i]);
            end
            check_value("ovf_vect_o", m_ovf, ovf_vect_o);
            check_value("intr_overflow_o", |(m_ovf & ovf_mask_i), intr_overflow_o);
            check_value("intr_quota_o", m_quota, intr_quota_o);
            for (int i = 0; i < N_COUNTERS; i++) begin
                m_hits[i] <= model_hit(i);
                m_wrap[i] <= 1'b0;
                // Soft reset beats preload which beats counting
                if (cnt_softrst_i) begin
                    m_cnt[i] <= '0;
                end else if (cnt_we_i && (int'(cnt_idx_i) == i)) begin
                    m_cnt[i] <= cnt_wdata_i;
                end else if (cnt_en_i && m_hits[i]) begin
                    m_cnt[i]  <= m_cnt[i] + 32'd1;
                    m_wrap[i] <= (m_cnt[i] == '1);
                end
            end
            if (ovf_softrst_i) begin
                m_ovf <= '0;
            end else if (ovf_en_i) begin
                m_ovf <= m_ovf | m_wrap;
            end
            m_quota <= (masked_sum(quota_mask_i) >= quota_limit_i);
        end
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic cycles(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    task automatic preload(input int k, input count_t value);
        cnt_we_i    = 1'b1;
        cnt_idx_i   = cnt_idx_t'(k);
        cnt_wdata_i = value;
        @(negedge clk_i);
        cnt_we_i    = 1'b0;
    endtask

    // One-cycle pulse on a system event
    task automatic pulse_event(input int ev);
        events_i[ev] = 1'b1;
        @(negedge clk_i);
        events_i = '0;
    endtask

    task automatic wait_ovf_bit(input int k);
        int n;
        n = 0;
        while (!ovf_vect_o[k] && n < WAIT_MAX) begin
            @(negedge clk_i);
            n++;
        end
        if (!ovf_vect_o[k]) begin
            timeout_errs++;
            $display("Timeout: overflow flag %0d never set at %0t", k, $time);
        end
    endtask

    task automatic wait_quota_high();
        int n;
        n = 0;
        while (!intr_quota_o && n < WAIT_MAX) begin
            @(negedge clk_i);
            n++;
        end
        if (!intr_quota_o) begin
            timeout_errs++;
            $display("Timeout: quota interrupt never rose at %0t", $time);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        void'($urandom(76));
        check_errs = 0;
        timeout_errs = 0;
        rstn_i = 1'b0;
        events_i = '0;
        route_sel_i = '0;
        selftest_i = ST_OFF;
        cnt_en_i = 1'b0;
        cnt_softrst_i = 1'b0;
        cnt_we_i = 1'b0;
        cnt_idx_i = '0;
        cnt_wdata_i = '0;
        ovf_en_i = 1'b0;
        ovf_softrst_i = 1'b0;
        ovf_mask_i = '0;
        quota_mask_i = '0;
        quota_limit_i = '1;
        repeat (4) @(negedge clk_i);
        rstn_i = 1'b1;
        cycles(2);

        // Ten enabled cycles in each self-test mode
        cnt_en_i = 1'b1;
        selftest_i = ST_ALL_ON;
        cycles(10);
        selftest_i = ST_ALL_OFF;
        cycles(10);
        selftest_i = ST_ONE_ON;
        cycles(10);
        selftest_i = ST_OFF;

        // Random routing where counters 1 and 2 always share an event
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < N_COUNTERS; i++) begin
                route_sel_i[i] = ev_sel_t'($urandom_range(N_SOC_EV - 1));
            end
            route_sel_i[2] = route_sel_i[1];
            for (int c = 0; c < 15; c++) begin
                events_i = $urandom();
                @(negedge clk_i);
            end
        end
        events_i = '0;
        cycles(3);

        // Single preload and then soft reset against a preload
        preload($urandom_range(N_COUNTERS - 1), $urandom());
        cycles(2);
        cnt_softrst_i = 1'b1;
        preload(4, 32'h1234_5678);
        cnt_softrst_i = 1'b0;
        cycles(2);

        // Wrap counter 3 through event 5
        ovf_en_i = 1'b1;
        ovf_mask_i = '0;
        ovf_mask_i[3] = 1'b1;
        route_sel_i[3] = ev_sel_t'(5);
        preload(3, '1);
        pulse_event(5);
        wait_ovf_bit(3);
        cycles(2);
        // Mask off drops the line and the soft reset clears the flags
        ovf_mask_i = '0;
        cycles(2);
        ovf_softrst_i = 1'b1;
        cycles(1);
        ovf_softrst_i = 1'b0;
        // Wrap again with flag capture off
        ovf_en_i = 1'b0;
        ovf_mask_i = '1;
        preload(3, '1);
        pulse_event(5);
        cycles(5);

        // Quota limits above, at and below the masked sum
        cnt_en_i = 1'b0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            preload(i, $urandom());
        end
        quota_mask_i = cnt_mask_t'($urandom_range(511, 1));
        q_sum = masked_sum(quota_mask_i);
        quota_limit_i = q_sum + 1'b1;
        cycles(3);
        quota_limit_i = q_sum;
        wait_quota_high();
        cycles(2);
        quota_limit_i = q_sum - 1'b1;
        cycles(3);

        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 check_errs, timeout_errs, dut_i.u_props.fail_cnt);
        if (check_errs + timeout_errs + dut_i.u_props.fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pmu_tb_props.sv
// PMU bound assertions
// Reset values, overflow interrupt masking and counter hold rules on the top level ports

`timescale 1ns/10ps
`default_nettype none

module pmu_tb_props (
    input wire logic                     clk_i,
    input wire logic                     rstn_i,
    input wire logic                     cnt_en_i,
    input wire logic                     cnt_we_i,
    input wire logic                     cnt_softrst_i,
    input wire pmu_count_pkg::cnt_mask_t ovf_mask_i,
    input wire pmu_count_pkg::count_t [pmu_count_pkg::N_COUNTERS-1:0] counts_i,
    input wire pmu_count_pkg::cnt_mask_t ovf_vect_i,
    input wire logic                     intr_overflow_i,
    input wire logic                     intr_quota_i
);

    // Failed assertions, read by the testbench at the end of the run
    int fail_cnt = 0;

    // Every output is zero on the edge after a reset edge
    a_reset_zero: assert property (@(posedge clk_i)
        !rstn_i |=> (counts_i == '0) && (ovf_vect_i == '0) && !intr_overflow_i && !intr_quota_i)
    else begin
        $error("outputs not zero after reset");
        fail_cnt++;
    end

    // Interrupt line is the masked OR of the sticky flags
    a_ovf_intr: assert property (@(posedge clk_i)
        intr_overflow_i == |(ovf_vect_i & ovf_mask_i))
    else begin
        $error("overflow interrupt does not match masked flags");
        fail_cnt++;
    end

    // No enable, preload or soft reset means counters hold
    a_count_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !cnt_en_i && !cnt_we_i && !cnt_softrst_i |=> $stable(counts_i))
    else begin
        $error("counters moved while idle");
        fail_cnt++;
    end

    // Soft reset clears the whole bank
    a_softrst_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cnt_softrst_i |=> (counts_i == '0))
    else begin
        $error("soft reset left a counter non-zero");
        fail_cnt++;
    end

endmodule

bind pmu_top pmu_tb_props u_props (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .cnt_en_i        (cnt_en_i),
    .cnt_we_i        (cnt_we_i),
    .cnt_softrst_i   (cnt_softrst_i),
    .ovf_mask_i      (ovf_mask_i),
    .counts_i        (counts_o),
    .ovf_vect_i      (ovf_vect_o),
    .intr_overflow_i (intr_overflow_o),
    .intr_quota_i    (intr_quota_o)
);

`default_nettype wire

//--- pmu_top.sv
// PMU top level
// Event router feeds the counter bank, the bank feeds the interrupt monitor

`timescale 1ns/10ps
`default_nettype none

module pmu_top (
    input  wire logic                       clk_i,
    input  wire logic                       rstn_i,

    // Event routing
    input  wire pmu_event_pkg::soc_events_t events_i,
    input  wire pmu_event_pkg::ev_sel_t [pmu_count_pkg::N_COUNTERS-1:0] route_sel_i,
    input  wire pmu_event_pkg::selftest_t   selftest_i,

    // Counter control and preload
    input  wire logic                       cnt_en_i,
    input  wire logic                       cnt_softrst_i,
    input  wire logic                       cnt_we_i,
    input  wire pmu_count_pkg::cnt_idx_t    cnt_idx_i,
    input  wire pmu_count_pkg::count_t      cnt_wdata_i,

    // Overflow control
    input  wire logic                       ovf_en_i,
    input  wire logic                       ovf_softrst_i,
    input  wire pmu_count_pkg::cnt_mask_t   ovf_mask_i,

    // Quota control
    input  wire pmu_count_pkg::cnt_mask_t   quota_mask_i,
    input  wire pmu_count_pkg::quota_t      quota_limit_i,

    // Status and interrupts
    output pmu_count_pkg::count_t [pmu_count_pkg::N_COUNTERS-1:0] counts_o,
    output pmu_count_pkg::cnt_mask_t        ovf_vect_o,
    output logic                            intr_overflow_o,
    output logic                            intr_quota_o
);

    import pmu_count_pkg::*;

    // Router to bank
    cnt_mask_t               hits;
    // Bank to monitor
    count_t [N_COUNTERS-1:0] counts;
    cnt_mask_t               wraps;

    // ------------------------------
    // Producer
    // ------------------------------
    pmu_event_router u_router (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .events_i    (events_i),
        .route_sel_i (route_sel_i),
        .selftest_i  (selftest_i),
        .hits_o      (hits)
    );

    // ------------------------------
    // Counters
    // ------------------------------
    pmu_counter_bank u_bank (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .hits_i    (hits),
        .en_i      (cnt_en_i),
        .softrst_i (cnt_softrst_i),
        .we_i      (cnt_we_i),
        .widx_i    (cnt_idx_i),
        .wdata_i   (cnt_wdata_i),
        .counts_o  (counts),
        .wraps_o   (wraps)
    );

    // ------------------------------
    // Consumer
    // ------------------------------
    pmu_intr_monitor u_monitor (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .counts_i        (counts),
        .wraps_i         (wraps),
        .ovf_en_i        (ovf_en_i),
        .ovf_softrst_i   (ovf_softrst_i),
        .ovf_mask_i      (ovf_mask_i),
        .quota_mask_i    (quota_mask_i),
        .quota_limit_i   (quota_limit_i),
        .ovf_vect_o      (ovf_vect_o),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

    // Counter values are software visible
    assign counts_o = counts;

endmodule

`default_nettype wire

//--- pmu_intr_monitor.sv
// PMU interrupt monitor
// Sticky overflow vector with masked interrupt, and registered quota-sum interrupt

`timescale 1ns/10ps
`default_nettype none

module pmu_intr_monitor (
    input  wire logic                     clk_i,
    input  wire logic                     rstn_i,
    // Live counter values from the bank
    input  wire pmu_count_pkg::count_t [pmu_count_pkg::N_COUNTERS-1:0] counts_i,
    // One-cycle wrap pulses from the bank
    input  wire pmu_count_pkg::cnt_mask_t wraps_i,
    input  wire logic                     ovf_en_i,
    input  wire logic                     ovf_softrst_i,
    input  wire pmu_count_pkg::cnt_mask_t ovf_mask_i,
    input  wire pmu_count_pkg::cnt_mask_t quota_mask_i,
    input  wire pmu_count_pkg::quota_t    quota_limit_i,
    output pmu_count_pkg::cnt_mask_t      ovf_vect_o,
    output logic                          intr_overflow_o,
    output logic                          intr_quota_o
);

    import pmu_count_pkg::*;

    cnt_mask_t ovf_vect_q;
    // Masked sum of counters, wide enough not to wrap
    quota_t    quota_sum;
    logic      intr_quota_q;

    // ------------------------------
    // Overflow
    // ------------------------------
    // Flags stay set until software clears them
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ovf_vect_q <= '0;
        end else if (ovf_softrst_i) begin
            ovf_vect_q <= '0;
        end else if (ovf_en_i) begin
            ovf_vect_q <= ovf_vect_q | wraps_i;
        end
    end

    // Any unmasked sticky flag raises the line
    assign intr_overflow_o = |(ovf_vect_q & ovf_mask_i);
    assign ovf_vect_o      = ovf_vect_q;

    // ------------------------------
    // Quota
    // ------------------------------
    always_comb begin
        quota_sum = '0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            if (quota_mask_i[i]) begin
                quota_sum = quota_sum + quota_t'(counts_i[i]);
            end
        end
    end

    // Compared on the counts visible before the edge, so one edge behind
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            intr_quota_q <= 1'b0;
        end else begin
            intr_quota_q <= (quota_sum >= quota_limit_i);
        end
    end

    assign intr_quota_o = intr_quota_q;

endmodule

`default_nettype wire

//--- pmu_counter_bank.sv
// PMU counter bank
// Nine 32-bit counters with enable, soft reset, single-counter preload and wrap pulses

`timescale 1ns/10ps
`default_nettype none

module pmu_counter_bank (
    input  wire logic                     clk_i,
    input  wire logic                     rstn_i,
    // Routed events from the crossbar
    input  wire pmu_count_pkg::cnt_mask_t hits_i,
    // Global count enable
    input  wire logic                     en_i,
    // Clears all counters
    input  wire logic                     softrst_i,
    // Preload strobe with target and value
    input  wire logic                     we_i,
    input  wire pmu_count_pkg::cnt_idx_t  widx_i,
    input  wire pmu_count_pkg::count_t    wdata_i,
    output pmu_count_pkg::count_t [pmu_count_pkg::N_COUNTERS-1:0] counts_o,
    // Pulse per counter stepping from all ones to zero
    output pmu_count_pkg::cnt_mask_t      wraps_o
);

    import pmu_count_pkg::*;

    count_t [N_COUNTERS-1:0] counts_q;
    count_t [N_COUNTERS-1:0] counts_d;
    cnt_mask_t               wraps_q;
    cnt_mask_t               wraps_d;

    // Counter plus one, top bit is the carry out
    logic [COUNT_W:0] incr [N_COUNTERS];

    // ------------------------------
    // Next counter values
    // ------------------------------
    always_comb begin
        for (int i = 0; i < N_COUNTERS; i++) begin
            incr[i]     = {1'b0, counts_q[i]} + 1'b1;
            counts_d[i] = counts_q[i];
            wraps_d[i]  = 1'b0;

            // Soft reset beats preload, preload beats counting
            if (softrst_i) begin
                counts_d[i] = '0;
            end else if (we_i && (widx_i == cnt_idx_t'(i))) begin
                counts_d[i] = wdata_i;
            end else if (en_i && hits_i[i]) begin
                counts_d[i] = incr[i][COUNT_W-1:0];
                // carry out means the counter rolled over
                wraps_d[i]  = incr[i][COUNT_W];
            end
        end
    end

    // ------------------------------
    // Registers
    // ------------------------------
    // Wrap flags leave on the same edge as the wrapped count
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            counts_q <= '0;
            wraps_q  <= '0;
        end else begin
            counts_q <= counts_d;
            wraps_q  <= wraps_d;
        end
    end

    assign counts_o = counts_q;
    assign wraps_o  = wraps_q;

endmodule

`default_nettype wire

//--- pmu_event_router.sv
// PMU event router
// Registered crossbar from system events to counter inputs, with self-test override

`timescale 1ns/10ps
`default_nettype none

module pmu_event_router (
    input  wire logic                       clk_i,
    input  wire logic                       rstn_i,
    // Raw system events
    input  wire pmu_event_pkg::soc_events_t events_i,
    // One selection field per counter
    input  wire pmu_event_pkg::ev_sel_t [pmu_count_pkg::N_COUNTERS-1:0] route_sel_i,
    input  wire pmu_event_pkg::selftest_t   selftest_i,
    // One hit bit per counter, valid for one cycle
    output pmu_count_pkg::cnt_mask_t        hits_o
);

    import pmu_event_pkg::*;
    import pmu_count_pkg::*;

    // Crossbar output before self-test override
    cnt_mask_t routed;
    // Value loaded into the hit register
    cnt_mask_t hits_d;
    cnt_mask_t hits_q;

    // ------------------------------
    // Crossbar
    // ------------------------------
    // Each counter picks one event, several counters may share an event
    always_comb begin
        routed = '0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            routed[i] = events_i[route_sel_i[i]];
        end
    end

    // ------------------------------
    // Self-test override
    // ------------------------------
    always_comb begin
        hits_d = routed;
        case (selftest_i)
            ST_OFF: begin
                hits_d = routed;
            end
            ST_ALL_ON: begin
                hits_d = '1;
            end
            ST_ALL_OFF: begin
                hits_d = '0;
            end
            ST_ONE_ON: begin
                // Only counter 0 sees activity
                hits_d    = '0;
                hits_d[0] = 1'b1;
            end
        endcase
    end

    // Sample point k, hits valid after edge k
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            hits_q <= '0;
        end else begin
            hits_q <= hits_d;
        end
    end

    assign hits_o = hits_q;

endmodule

`default_nettype wire

//--- pmu_count_pkg.sv
// PMU counter package
// Counter widths, counter indices, per-counter masks and quota sum type

`default_nettype none

package pmu_count_pkg;

    // ------------------------------
    // Counter bank sizes
    // ------------------------------
    // One counter per crossbar output
    localparam int N_COUNTERS = 9;
    localparam int COUNT_W    = 32;
    // Wide enough to address all counters for preload
    localparam int IDX_W      = 4;

    // Nine 32-bit values need 4 extra bits so the sum never wraps
    localparam int QUOTA_W    = COUNT_W + $clog2(N_COUNTERS);

    // ------------------------------
    // Types
    // ------------------------------
    // Single counter value
    typedef logic [COUNT_W-1:0] count_t;

    // Preload target
    typedef logic [IDX_W-1:0] cnt_idx_t;

    // One bit per counter, used for hits, wraps and masks
    typedef logic [N_COUNTERS-1:0] cnt_mask_t;

    // Quota limit and masked sum of counters
    typedef logic [QUOTA_W-1:0] quota_t;

endpackage

`default_nettype wire

//--- pmu_event_pkg.sv
// PMU event package
// System event vector, crossbar selection fields and self-test mode codes

`default_nettype none

package pmu_event_pkg;

    // ------------------------------
    // System event sizes
    // ------------------------------
    // Events coming from the cores and the interconnect
    localparam int N_SOC_EV = 32;
    // One crossbar field addresses any system event
    localparam int SEL_W = $clog2(N_SOC_EV);

    typedef logic [N_SOC_EV-1:0] soc_events_t;
    typedef logic [SEL_W-1:0]    ev_sel_t;

    // ------------------------------
    // Self-test modes
    // ------------------------------
    typedef logic [1:0] selftest_t;

    // Crossbar output passes through
    localparam selftest_t ST_OFF     = 2'b00;
    // Force every counter input high
    localparam selftest_t ST_ALL_ON  = 2'b01;
    // Force every counter input low
    localparam selftest_t ST_ALL_OFF = 2'b10;
    // Counter input 0 high, rest low
    localparam selftest_t ST_ONE_ON  = 2'b11;

endpackage

`default_nettype wire
